// File: common/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// width of one data word and of every register
`define DATA_WIDTH 32

// register index width, 32 registers
`define REG_ADDR_WIDTH 5

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// number of architectural registers
`define REG_COUNT (1 << `REG_ADDR_WIDTH)

`endif

// File: common/isaPkg.sv
package isaPkg;

	// primary opcode, instruction bits 31:26
	typedef enum logic [5:0] {
		SPECIAL = 6'd0,  // R-type, look at funct
		REGIMM  = 6'd1,  // bltz when rt is zero
		J       = 6'd2,
		JAL     = 6'd3,
		BEQ     = 6'd4,
		BNE     = 6'd5,
		BLEZ    = 6'd6,
		BGTZ    = 6'd7,
		ADDIU   = 6'd9,
		SLTI    = 6'd10,
		ANDI    = 6'd12,
		ORI     = 6'd13,
		XORI    = 6'd14,
		LUI     = 6'd15
	} opcodeT;

	// funct field of SPECIAL, bits 5:0
	typedef enum logic [5:0] {
		SLL  = 6'd0,
		SRL  = 6'd2,
		SRA  = 6'd3,
		JR   = 6'd8,
		ADDU = 6'd33,
		SUBU = 6'd35,
		AND  = 6'd36,
		OR   = 6'd37,
		XOR  = 6'd38,
		NOR  = 6'd39,
		SLT  = 6'd42  // signed compare
	} functT;

endpackage

// File: common/ctrlPkg.sv
package ctrlPkg;

	// operation carried into execute
	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		NOR,
		SLT,     // signed less than
		SLL,     // shifts work on operand B
		SRL,
		SRA,
		LUI,     // immediate to upper half
		PASS_B   // link value for jal
	} aluOpT;

	// destination register select
	typedef enum logic [1:0] {RD, RT, LINK} regDstT;

	// next PC source, anything but SEQ flushes IF/ID
	typedef enum logic [1:0] {
		SEQ,
		BRANCH,
		JUMP,
		REG
	} pcSrcT;

endpackage

// File: decode/registerFile.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module registerFile (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       writeEnable,
	input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
	input  logic [`DATA_WIDTH-1:0]     writeData,
	input  logic [`REG_ADDR_WIDTH-1:0] readAddrA,
	input  logic [`REG_ADDR_WIDTH-1:0] readAddrB,
	output logic [`DATA_WIDTH-1:0]     readDataA,
	output logic [`DATA_WIDTH-1:0]     readDataB
);
	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
	logic                   writeLive;

	assign writeLive = writeEnable && (writeAddr != '0);  // r0 never written

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) regs[i] <= '0;
		end else if (writeLive) begin
			regs[writeAddr] <= writeData;
		end
	end

	// same-cycle write shows up on the read ports
	assign readDataA = (writeLive && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (writeLive && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

// File: decode/controlUnit.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module controlUnit (
	input  isaPkg::opcodeT             opcode,
	input  isaPkg::functT              funct,
	input  logic [`REG_ADDR_WIDTH-1:0] rtField,
	output ctrlPkg::aluOpT             aluOp,
	output ctrlPkg::regDstT            regDst,
	output logic                       regWr,
	output logic                       aluSrcImm,
	output logic                       signExtend,
	output logic                       link,
	output logic [2:0]                 branchKind,
	output logic                       jump,
	output logic                       jumpReg
);

	always_comb begin
		// defaults describe a nop
		aluOp      = ctrlPkg::ADD;
		regDst     = ctrlPkg::RD;
		regWr      = 1'b0;
		aluSrcImm  = 1'b0;
		signExtend = 1'b0;
		link       = 1'b0;
		branchKind = 3'd0;  // low opcode bits of the branch, 0 when none
		jump       = 1'b0;
		jumpReg    = 1'b0;
		case (opcode)
			isaPkg::SPECIAL: begin
				regWr = 1'b1;
				case (funct)
					isaPkg::SLL:  aluOp = ctrlPkg::SLL;
					isaPkg::SRL:  aluOp = ctrlPkg::SRL;
					isaPkg::SRA:  aluOp = ctrlPkg::SRA;
					isaPkg::ADDU: aluOp = ctrlPkg::ADD;
					isaPkg::SUBU: aluOp = ctrlPkg::SUB;
					isaPkg::AND:  aluOp = ctrlPkg::AND;
					isaPkg::OR:   aluOp = ctrlPkg::OR;
					isaPkg::XOR:  aluOp = ctrlPkg::XOR;
					isaPkg::NOR:  aluOp = ctrlPkg::NOR;
					isaPkg::SLT:  aluOp = ctrlPkg::SLT;
					isaPkg::JR: begin
						regWr   = 1'b0;
						jumpReg = 1'b1;
					end
					default: regWr = 1'b0;  // unknown funct
				endcase
			end
			isaPkg::REGIMM: if (rtField == '0) branchKind = 3'(isaPkg::REGIMM);  // bltz only
			isaPkg::BEQ:    branchKind = 3'(isaPkg::BEQ);
			isaPkg::BNE:    branchKind = 3'(isaPkg::BNE);
			isaPkg::BLEZ:   branchKind = 3'(isaPkg::BLEZ);
			isaPkg::BGTZ:   branchKind = 3'(isaPkg::BGTZ);
			isaPkg::J:      jump = 1'b1;
			isaPkg::JAL: begin
				jump   = 1'b1;
				link   = 1'b1;
				regWr  = 1'b1;
				regDst = ctrlPkg::LINK;
				aluOp  = ctrlPkg::PASS_B;
			end
			default: begin
				// immediate group, rt is the destination
				regDst    = ctrlPkg::RT;
				aluSrcImm = 1'b1;
				regWr     = 1'b1;
				case (opcode)
					isaPkg::ADDIU: begin
						aluOp      = ctrlPkg::ADD;
						signExtend = 1'b1;
					end
					isaPkg::SLTI: begin
						aluOp      = ctrlPkg::SLT;
						signExtend = 1'b1;
					end
					isaPkg::ANDI: aluOp = ctrlPkg::AND;
					isaPkg::ORI:  aluOp = ctrlPkg::OR;
					isaPkg::XORI: aluOp = ctrlPkg::XOR;
					isaPkg::LUI:  aluOp = ctrlPkg::LUI;
					default:      regWr = 1'b0;  // unknown opcode
				endcase
			end
		endcase
	end

endmodule

// File: decode/pipelineId.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module pipelineId (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`DATA_WIDTH-1:0]     idPc,
	input  logic [`DATA_WIDTH-1:0]     idInstruction,
	input  logic                       wbValid,
	input  logic [`REG_ADDR_WIDTH-1:0] wbReg,
	input  logic [`DATA_WIDTH-1:0]     wbData,
	input  logic                       fwdRegWr,
	input  logic [`REG_ADDR_WIDTH-1:0] fwdDest,
	input  logic [`DATA_WIDTH-1:0]     fwdData,
	output ctrlPkg::pcSrcT             pcSrc,
	output logic [`DATA_WIDTH-1:0]     branchTarget,
	output logic [`DATA_WIDTH-1:0]     jumpTarget,
	output logic [`DATA_WIDTH-1:0]     regTarget,
	output ctrlPkg::aluOpT             exAluOp,
	output logic [`DATA_WIDTH-1:0]     exOperandA,
	output logic [`DATA_WIDTH-1:0]     exOperandB,
	output logic [4:0]                 exShamt,
	output logic [`REG_ADDR_WIDTH-1:0] exDest,
	output logic                       exRegWr
);
	logic [`REG_ADDR_WIDTH-1:0] rs, rt, rd;
	logic [15:0]                imm;
	logic [`DATA_WIDTH-1:0]     pcPlus4, immExt, rfDataA, rfDataB, operandA, operandB;
	ctrlPkg::regDstT            regDst;
	logic                       regWr, aluSrcImm, signExtend, link, jump, jumpReg;
	logic [2:0]                 branchKind;
	logic                       branchTaken;

	assign rs  = idInstruction[25:21];
	assign rt  = idInstruction[20:16];
	assign rd  = idInstruction[15:11];
	assign imm = idInstruction[15:0];

	controlUnit control_inst (
		.opcode(isaPkg::opcodeT'(idInstruction[31:26])), .funct(isaPkg::functT'(idInstruction[5:0])),
		.rtField(rt), .aluOp(exAluOp), .regDst(regDst), .regWr(regWr), .aluSrcImm(aluSrcImm),
		.signExtend(signExtend), .link(link), .branchKind(branchKind), .jump(jump),
		.jumpReg(jumpReg)
	);

	// writeback port sits here, bypass is inside the file
	registerFile registerFile_inst (
		.clk(clk), .reset(reset), .writeEnable(wbValid), .writeAddr(wbReg), .writeData(wbData),
		.readAddrA(rs), .readAddrB(rt), .readDataA(rfDataA), .readDataB(rfDataB)
	);

	// result of the instruction one ahead, still in execute
	assign operandA = (fwdRegWr && fwdDest != '0 && fwdDest == rs) ? fwdData : rfDataA;
	assign operandB = (fwdRegWr && fwdDest != '0 && fwdDest == rt) ? fwdData : rfDataB;

	assign pcPlus4      = idPc + `DATA_WIDTH'(4);
	assign immExt       = {{(`DATA_WIDTH-16){signExtend & imm[15]}}, imm};
	assign branchTarget = pcPlus4 + {{(`DATA_WIDTH-18){imm[15]}}, imm, 2'b00};
	assign jumpTarget   = {pcPlus4[31:28], idInstruction[25:0], 2'b00};
	assign regTarget    = operandA;  // jr

	always_comb begin
		case (branchKind)
			3'(isaPkg::REGIMM): branchTaken = operandA[31];  // bltz
			3'(isaPkg::BEQ):    branchTaken = (operandA == operandB);
			3'(isaPkg::BNE):    branchTaken = (operandA != operandB);
			3'(isaPkg::BLEZ):   branchTaken = operandA[31] || (operandA == '0);
			3'(isaPkg::BGTZ):   branchTaken = !operandA[31] && (operandA != '0);
			default:            branchTaken = 1'b0;
		endcase
		if (jumpReg) pcSrc = ctrlPkg::REG;
		else if (jump) pcSrc = ctrlPkg::JUMP;
		else if (branchTaken) pcSrc = ctrlPkg::BRANCH;
		else pcSrc = ctrlPkg::SEQ;
	end

	assign exOperandA = operandA;
	assign exOperandB = link ? pcPlus4 : (aluSrcImm ? immExt : operandB);
	assign exShamt    = idInstruction[10:6];
	assign exRegWr    = regWr && (idInstruction != '0);  // flushed slot writes nothing

	always_comb begin
		case (regDst)
			ctrlPkg::RT:   exDest = rt;
			ctrlPkg::LINK: exDest = {`REG_ADDR_WIDTH{1'b1}};  // r31
			default:       exDest = rd;
		endcase
	end

endmodule

// File: src/fetchStage.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module fetchStage (
	input  logic                   clk,
	input  logic                   reset,
	input  ctrlPkg::pcSrcT         pcSrc,
	input  logic [`DATA_WIDTH-1:0] branchTarget,
	input  logic [`DATA_WIDTH-1:0] jumpTarget,
	input  logic [`DATA_WIDTH-1:0] regTarget,
	output logic [`DATA_WIDTH-1:0] imemAddr,
	input  logic [`DATA_WIDTH-1:0] imemData,
	output logic [`DATA_WIDTH-1:0] idPc,
	output logic [`DATA_WIDTH-1:0] idInstruction
);
	logic [`DATA_WIDTH-1:0] pc, nextPc;

	assign imemAddr = pc;

	always_comb begin
		case (pcSrc)
			ctrlPkg::BRANCH: nextPc = branchTarget;
			ctrlPkg::JUMP:   nextPc = jumpTarget;
			ctrlPkg::REG:    nextPc = regTarget;
			default:         nextPc = pc + `DATA_WIDTH'(4);
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc            <= `RESET_PC;
			idInstruction <= '0;
		end else begin
			pc            <= nextPc;
			idInstruction <= (pcSrc == ctrlPkg::SEQ) ? imemData : '0;  // redirect kills the fetched word
		end
	end

	always_ff @(posedge clk) idPc <= pc;

endmodule

// File: src/executeStage.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module executeStage (
	input  logic                       clk,
	input  logic                       reset,
	input  ctrlPkg::aluOpT             exAluOp,
	input  logic [`DATA_WIDTH-1:0]     exOperandA,
	input  logic [`DATA_WIDTH-1:0]     exOperandB,
	input  logic [4:0]                 exShamt,
	input  logic [`REG_ADDR_WIDTH-1:0] exDest,
	input  logic                       exRegWr,
	output logic                       fwdRegWr,
	output logic [`REG_ADDR_WIDTH-1:0] fwdDest,
	output logic [`DATA_WIDTH-1:0]     fwdData,
	output logic                       wbValid,
	output logic [`REG_ADDR_WIDTH-1:0] wbReg,
	output logic [`DATA_WIDTH-1:0]     wbData
);
	ctrlPkg::aluOpT         aluOpReg;
	logic [`DATA_WIDTH-1:0] operandAReg, operandBReg, aluResult;
	logic [4:0]             shamtReg;

	// ID/EX, control part
	always_ff @(posedge clk) begin
		if (reset) begin
			aluOpReg <= ctrlPkg::ADD;
			fwdDest  <= '0;
			fwdRegWr <= 1'b0;
		end else begin
			aluOpReg <= exAluOp;
			fwdDest  <= exDest;
			fwdRegWr <= exRegWr;
		end
	end

	always_ff @(posedge clk) begin
		operandAReg <= exOperandA;
		operandBReg <= exOperandB;
		shamtReg    <= exShamt;
	end

	always_comb begin
		case (aluOpReg)
			ctrlPkg::ADD:    aluResult = operandAReg + operandBReg;
			ctrlPkg::SUB:    aluResult = operandAReg - operandBReg;
			ctrlPkg::AND:    aluResult = operandAReg & operandBReg;
			ctrlPkg::OR:     aluResult = operandAReg | operandBReg;
			ctrlPkg::XOR:    aluResult = operandAReg ^ operandBReg;
			ctrlPkg::NOR:    aluResult = ~(operandAReg | operandBReg);
			ctrlPkg::SLT:    aluResult = {{(`DATA_WIDTH-1){1'b0}},
				$signed(operandAReg) < $signed(operandBReg)};
			ctrlPkg::SLL:    aluResult = operandBReg << shamtReg;
			ctrlPkg::SRL:    aluResult = operandBReg >> shamtReg;
			ctrlPkg::SRA:    aluResult = $signed(operandBReg) >>> shamtReg;  // keeps sign
			ctrlPkg::LUI:    aluResult = {operandBReg[15:0], 16'b0};
			ctrlPkg::PASS_B: aluResult = operandBReg;
			default:         aluResult = '0;
		endcase
	end

	assign fwdData = aluResult;  // back to decode for forwarding

	// EX/WB
	always_ff @(posedge clk) begin
		if (reset) wbValid <= 1'b0;
		else wbValid <= fwdRegWr && (fwdDest != '0);
	end

	always_ff @(posedge clk) begin
		wbReg  <= fwdDest;
		wbData <= aluResult;
	end

endmodule

// File: src/mipsCore.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module mipsCore (
	input  logic                       clk,
	input  logic                       reset,
	output logic [`DATA_WIDTH-1:0]     imemAddr,
	input  logic [`DATA_WIDTH-1:0]     imemData,
	output logic                       wbValid,
	output logic [`REG_ADDR_WIDTH-1:0] wbReg,
	output logic [`DATA_WIDTH-1:0]     wbData
);
	// fetch and decode
	logic [`DATA_WIDTH-1:0]     idPc, idInstruction;
	ctrlPkg::pcSrcT             pcSrc;
	logic [`DATA_WIDTH-1:0]     branchTarget, jumpTarget, regTarget;
	// decode to execute
	ctrlPkg::aluOpT             exAluOp;
	logic [`DATA_WIDTH-1:0]     exOperandA, exOperandB;
	logic [4:0]                 exShamt;
	logic [`REG_ADDR_WIDTH-1:0] exDest;
	logic                       exRegWr;
	// execute back to decode
	logic                       fwdRegWr;
	logic [`REG_ADDR_WIDTH-1:0] fwdDest;
	logic [`DATA_WIDTH-1:0]     fwdData;

	fetchStage fetchStage_inst (
		.clk(clk), .reset(reset), .pcSrc(pcSrc), .branchTarget(branchTarget),
		.jumpTarget(jumpTarget), .regTarget(regTarget), .imemAddr(imemAddr),
		.imemData(imemData), .idPc(idPc), .idInstruction(idInstruction)
	);

	pipelineId pipelineId_inst (
		.clk(clk), .reset(reset), .idPc(idPc), .idInstruction(idInstruction),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.fwdRegWr(fwdRegWr), .fwdDest(fwdDest), .fwdData(fwdData),
		.pcSrc(pcSrc), .branchTarget(branchTarget), .jumpTarget(jumpTarget),
		.regTarget(regTarget), .exAluOp(exAluOp), .exOperandA(exOperandA),
		.exOperandB(exOperandB), .exShamt(exShamt), .exDest(exDest), .exRegWr(exRegWr)
	);

	executeStage executeStage_inst (
		.clk(clk), .reset(reset), .exAluOp(exAluOp), .exOperandA(exOperandA),
		.exOperandB(exOperandB), .exShamt(exShamt), .exDest(exDest), .exRegWr(exRegWr),
		.fwdRegWr(fwdRegWr), .fwdDest(fwdDest), .fwdData(fwdData),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

endmodule

// File: test/programRom.sv
`timescale 1ns/1ns

module programRom (
	input  logic [31:0] addr,
	output logic [31:0] data
);
	localparam int WORDS = 256;

	logic [31:0] mem [WORDS];

	assign data = mem[addr[9:2]];  // word addressed, same-cycle read

	// sll to r0 with the word index in rs and rt, a stray fetch writes nothing
	task automatic fillAll();
		for (int i = 0; i < WORDS; i++) begin
			mem[i[7:0]] = {8'd0, i[7:0], 16'd0};
		end
	endtask

	task automatic writeWord(int index, logic [31:0] word);
		mem[index[7:0]] = word;
	endtask

	initial fillAll();

endmodule

// File: test/tbMipsCore.sv
`timescale 1ns/1ns
`include "core_defines.svh"

module tbMipsCore;
	localparam int          CLK_PERIOD = 40;
	localparam int          TB_TIMEOUT = 40;  // cycles allowed per expected write
	localparam logic [31:0] LFSR_SEED  = 32'h2ce8_66b0;
	localparam isaPkg::functT RTYPE_FUNCTS [10] = '{isaPkg::SLL, isaPkg::SRL, isaPkg::SRA,
		isaPkg::ADDU, isaPkg::SUBU, isaPkg::AND, isaPkg::OR, isaPkg::XOR, isaPkg::NOR, isaPkg::SLT};
	localparam isaPkg::opcodeT IMM_OPCODES [6] = '{isaPkg::ADDIU, isaPkg::SLTI, isaPkg::ANDI,
		isaPkg::ORI, isaPkg::XORI, isaPkg::LUI};

	logic        clk;
	logic        reset;
	logic [31:0] imemAddr, imemData, wbData;
	logic        wbValid;
	logic [4:0]  wbReg;
	logic [31:0] lfsr;
	logic [31:0] prog [$];     // program of the current test
	logic [4:0]  expReg [$];   // reference writes in program order
	logic [31:0] expData [$];

	mipsCore mipsCore_inst (
		.clk(clk), .reset(reset), .imemAddr(imemAddr), .imemData(imemData),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

	programRom programRom_inst (.addr(imemAddr), .data(imemData));

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] rOp(isaPkg::functT fn, int rd, int rs, int rt, int sa);
		return {isaPkg::SPECIAL, rs[4:0], rt[4:0], rd[4:0], sa[4:0], fn};
	endfunction

	function automatic logic [31:0] iOp(isaPkg::opcodeT op, int rt, int rs, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] jOp(isaPkg::opcodeT op, int index);
		return {op, index[25:0]};
	endfunction

	// galois form with taps 32 22 2 1
	function automatic logic [31:0] randomBits(int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			bits = {bits[30:0], lfsr[0]};
		end
		return bits;
	endfunction

	task automatic emit(logic [31:0] word);
		prog.push_back(word);
	endtask

	task automatic abortRun(string why);
		$display("sim failed");
		$fatal(1, "%s", why);
	endtask

	task automatic checkValue(string signal, logic [31:0] got, logic [31:0] want);
		if (got !== want) begin
			$display("ERR %s got %h expected %h", signal, got, want);
			abortRun($sformatf("%s does not match the reference", signal));
		end
	endtask

	// ISA level model without delay slots where jal links pc+4
	task automatic runModel();
		logic [31:0] regs [32];
		logic [31:0] pc, nextPc, target, ins, a, b, immS, immZ, result;
		logic [4:0]  dest;
		logic        writes;
		int          idx, steps;
		foreach (regs[r]) regs[r] = '0;
		expReg.delete();
		expData.delete();
		pc = '0;
		idx = 0;
		steps = 0;
		while (idx < prog.size() && steps < 200) begin
			ins    = prog[idx];
			a      = regs[ins[25:21]];
			b      = regs[ins[20:16]];
			immS   = {{16{ins[15]}}, ins[15:0]};
			immZ   = {16'd0, ins[15:0]};
			nextPc = pc + 32'd4;
			target = nextPc + {immS[29:0], 2'b00};
			dest   = ins[20:16];
			result = '0;
			writes = 1'b1;
			case (ins[31:26])
				isaPkg::SPECIAL: begin
					dest = ins[15:11];
					case (ins[5:0])
						isaPkg::SLL:  result = b << ins[10:6];
						isaPkg::SRL:  result = b >> ins[10:6];
						isaPkg::SRA:  result = $signed(b) >>> ins[10:6];
						isaPkg::ADDU: result = a + b;
						isaPkg::SUBU: result = a - b;
						isaPkg::AND:  result = a & b;
						isaPkg::OR:   result = a | b;
						isaPkg::XOR:  result = a ^ b;
						isaPkg::NOR:  result = ~(a | b);
						isaPkg::SLT:  result = {31'd0, ($signed(a) < $signed(b))};
						isaPkg::JR: begin
							writes = 1'b0;
							nextPc = a;
						end
						default: writes = 1'b0;
					endcase
				end
				isaPkg::ADDIU: result = a + immS;
				isaPkg::SLTI:  result = {31'd0, ($signed(a) < $signed(immS))};
				isaPkg::ANDI:  result = a & immZ;
				isaPkg::ORI:   result = a | immZ;
				isaPkg::XORI:  result = a ^ immZ;
				isaPkg::LUI:   result = {ins[15:0], 16'd0};
				isaPkg::JAL: begin
					dest   = 5'd31;
					result = nextPc;
					nextPc = {nextPc[31:28], ins[25:0], 2'b00};
				end
				default: begin
					writes = 1'b0;
					case (ins[31:26])
						isaPkg::J:      nextPc = {nextPc[31:28], ins[25:0], 2'b00};
						isaPkg::REGIMM: if (ins[20:16] == 5'd0 && a[31]) nextPc = target;
						isaPkg::BEQ:    if (a == b) nextPc = target;
						isaPkg::BNE:    if (a != b) nextPc = target;
						isaPkg::BLEZ:   if ($signed(a) <= 0) nextPc = target;
						isaPkg::BGTZ:   if ($signed(a) > 0) nextPc = target;
						default:        nextPc = nextPc;
					endcase
				end
			endcase
			if (writes && dest != 5'd0) begin
				regs[dest] = result;
				expReg.push_back(dest);
				expData.push_back(result);
			end
			pc = nextPc;
			idx = int'(pc >> 2);
			steps++;
		end
	endtask

	task automatic resetCore();
		@(posedge clk);
		reset <= 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	endtask

	// loads the program and compares the core's write trace with the model
	task automatic runProgram(string name);
		int waited;
		$display("running %s, %0d words", name, prog.size());
		programRom_inst.fillAll();
		foreach (prog[i]) programRom_inst.writeWord(i, prog[i]);
		runModel();
		resetCore();
		@(negedge clk);
		checkValue("imemAddr", imemAddr, `RESET_PC);  // first fetch out of reset
		for (int i = 0; i < expReg.size(); i++) begin
			waited = 0;
			@(negedge clk);
			while (!wbValid) begin
				if (waited == TB_TIMEOUT) begin
					abortRun($sformatf("%s: write %0d of %0d, to r%0d, never arrived",
						name, i + 1, expReg.size(), expReg[i]));
				end
				waited++;
				@(negedge clk);
			end
			checkValue("wbReg", 32'(wbReg), 32'(expReg[i]));
			checkValue("wbData", wbData, expData[i]);
		end
		// flushed slots and r0 writes must stay silent
		repeat (prog.size() + 6) begin
			@(negedge clk);
			checkValue("wbValid", 32'(wbValid), 32'd0);
		end
	endtask

	task automatic aluTest();
		prog.delete();
		emit(iOp(isaPkg::LUI, 1, 0, 'h8765));
		emit(iOp(isaPkg::ORI, 1, 1, 'h4321));
		emit(iOp(isaPkg::ADDIU, 2, 0, 243));
		emit(rOp(isaPkg::ADDU, 3, 1, 2, 0));
		emit(rOp(isaPkg::SUBU, 4, 1, 2, 0));
		emit(rOp(isaPkg::AND, 5, 1, 2, 0));
		emit(rOp(isaPkg::OR, 6, 1, 2, 0));
		emit(rOp(isaPkg::XOR, 7, 1, 2, 0));
		emit(rOp(isaPkg::NOR, 8, 1, 2, 0));
		emit(rOp(isaPkg::SLT, 9, 1, 2, 0));   // negative below positive
		emit(rOp(isaPkg::SLT, 10, 2, 1, 0));
		emit(rOp(isaPkg::SLL, 11, 0, 1, 4));
		emit(rOp(isaPkg::SRL, 12, 0, 1, 7));
		emit(rOp(isaPkg::SRA, 13, 0, 1, 7));
		emit(rOp(isaPkg::SRA, 14, 0, 2, 3));
		runProgram("alu");
	endtask

	task automatic immTest();
		prog.delete();
		emit(iOp(isaPkg::ADDIU, 1, 0, -16));
		emit(iOp(isaPkg::SLTI, 2, 1, -1));
		emit(iOp(isaPkg::SLTI, 3, 1, 'h8000));
		emit(iOp(isaPkg::ANDI, 4, 1, 'hff0f));   // upper half cleared
		emit(iOp(isaPkg::ORI, 5, 0, 'h8001));
		emit(iOp(isaPkg::XORI, 6, 1, 'hffff));
		emit(iOp(isaPkg::LUI, 7, 0, 'habcd));
		emit(iOp(isaPkg::ADDIU, 0, 1, 5));
		emit(iOp(isaPkg::ADDIU, 8, 7, -1));
		runProgram("immediate");
	endtask

	task automatic forwardTest();
		prog.delete();
		emit(iOp(isaPkg::ADDIU, 1, 0, 7));
		emit(rOp(isaPkg::ADDU, 2, 1, 1, 0));    // distance one
		emit(iOp(isaPkg::ADDIU, 3, 0, 1));
		emit(rOp(isaPkg::SUBU, 4, 2, 3, 0));    // distance two and one
		emit(rOp(isaPkg::SLL, 5, 0, 4, 2));
		emit(iOp(isaPkg::ADDIU, 6, 0, 3));
		emit(iOp(isaPkg::BNE, 0, 6, 1));        // branch on the value just made
		emit(iOp(isaPkg::ADDIU, 20, 0, 1));
		emit(iOp(isaPkg::ADDIU, 7, 0, -1));
		emit(iOp(isaPkg::ADDIU, 8, 6, 4));
		emit(iOp(isaPkg::REGIMM, 0, 7, 1));     // bltz at distance two
		emit(iOp(isaPkg::ADDIU, 21, 0, 2));
		emit(rOp(isaPkg::ADDU, 9, 7, 8, 0));
		runProgram("forwarding");
	endtask

	task automatic branchTest();
		prog.delete();
		emit(iOp(isaPkg::ADDIU, 1, 0, -5));
		emit(iOp(isaPkg::ADDIU, 2, 0, 5));
		emit(iOp(isaPkg::REGIMM, 0, 1, 1));     // bltz taken
		emit(iOp(isaPkg::ADDIU, 20, 0, 1));
		emit(iOp(isaPkg::REGIMM, 0, 2, 1));
		emit(iOp(isaPkg::ADDIU, 3, 0, 17));
		emit(iOp(isaPkg::BEQ, 2, 2, 2));        // skips two words
		emit(iOp(isaPkg::ADDIU, 20, 0, 2));
		emit(iOp(isaPkg::ADDIU, 21, 0, 3));
		emit(iOp(isaPkg::BEQ, 1, 2, 1));
		emit(iOp(isaPkg::ADDIU, 4, 0, 18));
		emit(iOp(isaPkg::BNE, 1, 2, 1));
		emit(iOp(isaPkg::ADDIU, 20, 0, 4));
		emit(iOp(isaPkg::BNE, 2, 2, 1));
		emit(iOp(isaPkg::ADDIU, 5, 0, 19));
		emit(iOp(isaPkg::BLEZ, 0, 0, 1));       // zero is taken
		emit(iOp(isaPkg::ADDIU, 20, 0, 5));
		emit(iOp(isaPkg::BLEZ, 0, 2, 1));
		emit(iOp(isaPkg::ADDIU, 6, 0, 20));
		emit(iOp(isaPkg::BGTZ, 0, 2, 1));
		emit(iOp(isaPkg::ADDIU, 20, 0, 6));
		emit(iOp(isaPkg::BGTZ, 0, 1, 1));
		emit(iOp(isaPkg::ADDIU, 7, 0, 21));
		emit(iOp(isaPkg::ADDIU, 9, 0, 3));      // loop counter
		emit(iOp(isaPkg::ADDIU, 9, 9, -1));
		emit(iOp(isaPkg::BGTZ, 0, 9, -2));      // backward to the decrement
		runProgram("branch");
	endtask

	task automatic jumpTest();
		prog.delete();
		emit(iOp(isaPkg::ADDIU, 1, 0, 32));     // address of word 8
		emit(jOp(isaPkg::J, 3));
		emit(iOp(isaPkg::ADDIU, 20, 0, 1));
		emit(jOp(isaPkg::JAL, 6));
		emit(iOp(isaPkg::ADDIU, 21, 0, 2));     // reached again through jr r31
		emit(rOp(isaPkg::JR, 0, 1, 0, 0));
		emit(rOp(isaPkg::ADDU, 22, 31, 0, 0));
		emit(rOp(isaPkg::JR, 0, 31, 0, 0));
		emit(iOp(isaPkg::ADDIU, 23, 0, 3));
		emit(rOp(isaPkg::ADDU, 0, 1, 1, 0));
		runProgram("jump");
	endtask

	task automatic randomTest();
		logic [3:0] kind;
		int         rd, rs, rt, field;
		for (int p = 0; p < 3; p++) begin
			prog.delete();
			for (int n = 0; n < 24; n++) begin
				kind  = 4'(randomBits(4));
				rd    = int'(randomBits(3));   // r0 to r7 keeps dependencies dense
				rs    = int'(randomBits(3));
				rt    = int'(randomBits(3));
				if (kind < 4'd10) begin
					field = int'(randomBits(5));
					emit(rOp(RTYPE_FUNCTS[kind], rd, rs, rt, field));
				end else begin
					field = int'(randomBits(16));
					emit(iOp(IMM_OPCODES[3'(kind - 4'd10)], rt, rs, field));
				end
			end
			runProgram($sformatf("random %0d", p));
		end
	endtask

	initial begin
		reset = 1'b1;
		lfsr = LFSR_SEED;
		aluTest();
		immTest();
		forwardTest();
		branchTest();
		jumpTest();
		randomTest();
		$display("sim passed");
		$finish;
	end

endmodule

// File: compile.f
+incdir+common
common/isaPkg.sv
common/ctrlPkg.sv
decode/registerFile.sv
decode/controlUnit.sv
decode/pipelineId.sv
src/fetchStage.sv
src/executeStage.sv
src/mipsCore.sv
test/programRom.sv
test/tbMipsCore.sv

// File: run.sh
#!/bin/sh
# builds the core testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tbMipsCore -f compile.f -o simMipsCore
./obj_dir/simMipsCore
